/* fetch_buffer_top.f */
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/fetch_capture.sv
hw/fetch_queue.sv
hw/instr_predecode.sv
hw/fetch_buffer_top.sv
test/fetch_buffer_assertions.sv
test/fetch_buffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fetch buffer testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module fetch_buffer_tb -f fetch_buffer_top.f \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vfetch_buffer_tb 2>&1)"
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "TB PASSED" && exit 0 || exit 1

/* test/fetch_buffer_tb.sv */
// Directed testbench for the instruction fetch buffer with an in-order reference model
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer_tb;

    localparam int ABITS   = 3;
    localparam int DEPTH   = 2 ** ABITS;
    localparam int TIMEOUT = 200;
    localparam int BURST   = 40;

    logic                      i_clk;
    logic                      i_nrst;
    logic                      i_resp_valid;
    fetch_pkg::addr_t          i_resp_addr;
    isa_pkg::instr_t           i_resp_data;
    logic                      i_resp_err;
    logic                      o_resp_ready;
    logic                      i_dec_accept;
    logic                      o_instr_valid;
    fetch_pkg::decoded_instr_t o_instr;

    // Expected results in the order the decoder must see them
    fetch_pkg::decoded_instr_t ref_q[$];
    int                        seed;

    fetch_buffer_top #(
        .ABITS (ABITS)
    ) dut_i (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_resp_valid  (i_resp_valid),
        .i_resp_addr   (i_resp_addr),
        .i_resp_data   (i_resp_data),
        .i_resp_err    (i_resp_err),
        .o_resp_ready  (o_resp_ready),
        .i_dec_accept  (i_dec_accept),
        .o_instr_valid (o_instr_valid),
        .o_instr       (o_instr)
    );

    always #2 i_clk = ~i_clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %0h expected %0h",
                                $time, name, got, exp));
        end
    endtask

    // All driving happens 1 ns after a rising edge
    task automatic step();
        @(posedge i_clk);
        #1;
    endtask

    // Class taken from the RV32I major opcode table on opcode bits 6:2
    function automatic isa_pkg::instr_class_e expected_class(input fetch_pkg::addr_t pc,
                                                             input isa_pkg::instr_t w,
                                                             input logic err);
        if (err || (pc[1:0] != 2'b00)) begin
            return isa_pkg::CLS_FAULT;
        end
        if (w[1:0] != 2'b11) begin
            return isa_pkg::CLS_ILLEGAL;
        end
        case (w[6:2])
            5'b00100, 5'b01100, 5'b01101, 5'b00101: return isa_pkg::CLS_ALU;
            5'b00000: return isa_pkg::CLS_LOAD;
            5'b01000: return isa_pkg::CLS_STORE;
            5'b11000: return isa_pkg::CLS_BRANCH;
            5'b11011: return isa_pkg::CLS_JAL;
            5'b11001: return isa_pkg::CLS_JALR;
            5'b11100: return isa_pkg::CLS_SYSTEM;
            default:  return isa_pkg::CLS_ILLEGAL;
        endcase
    endfunction

    function automatic fetch_pkg::addr_t expected_target(input fetch_pkg::addr_t pc,
                                                         input isa_pkg::instr_t w,
                                                         input isa_pkg::instr_class_e cls);
        logic signed [12:0] b_off;
        logic signed [20:0] j_off;
        b_off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        if (cls == isa_pkg::CLS_BRANCH) begin
            return pc + int'(b_off);
        end
        if (cls == isa_pkg::CLS_JAL) begin
            return pc + int'(j_off);
        end
        return '0;
    endfunction

    // bne x1, x2 with the given byte offset
    function automatic isa_pkg::instr_t encode_branch(input int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b001, o[4:1], o[11], 7'b1100011};
    endfunction

    // jal x1 with the given byte offset
    function automatic isa_pkg::instr_t encode_jal(input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
    endfunction

    // Mostly valid opcodes, with some unknown and some compressed words mixed in
    function automatic isa_pkg::instr_t random_word();
        logic [31:0] w;
        int          sel;
        w   = $random(seed);
        sel = $unsigned($random(seed)) % 12;
        case (sel)
            0:       w[6:0] = 7'b0110011;
            1:       w[6:0] = 7'b0010011;
            2:       w[6:0] = 7'b0110111;
            3:       w[6:0] = 7'b0010111;
            4:       w[6:0] = 7'b0000011;
            5:       w[6:0] = 7'b0100011;
            6:       w[6:0] = 7'b1100011;
            7:       w[6:0] = 7'b1101111;
            8:       w[6:0] = 7'b1100111;
            9:       w[6:0] = 7'b1110011;
            10:      w[6:0] = 7'b0001011;
            default: w      = w;
        endcase
        return w;
    endfunction

    task automatic expect_entry(input fetch_pkg::addr_t pc, input isa_pkg::instr_t w,
                                input isa_pkg::instr_class_e cls,
                                input fetch_pkg::addr_t tgt);
        fetch_pkg::decoded_instr_t d;
        d.pc     = pc;
        d.instr  = w;
        d.iclass = cls;
        d.target = tgt;
        ref_q.push_back(d);
    endtask

    task automatic expect_model(input fetch_pkg::addr_t pc, input isa_pkg::instr_t w,
                                input logic err);
        isa_pkg::instr_class_e cls;
        cls = expected_class(pc, w, err);
        expect_entry(pc, w, cls, expected_target(pc, w, cls));
    endtask

    task automatic send_resp(input fetch_pkg::addr_t pc, input isa_pkg::instr_t w,
                             input logic err);
        int waited;
        waited = 0;
        while (!o_resp_ready) begin
            if (waited == TIMEOUT) begin
                abort_run("Timeout while waiting for o_resp_ready to rise");
            end
            step();
            waited++;
        end
        i_resp_valid = 1'b1;
        i_resp_addr  = pc;
        i_resp_data  = w;
        i_resp_err   = err;
        step();
        i_resp_valid = 1'b0;
        i_resp_err   = 1'b0;
    endtask

    task automatic check_head();
        fetch_pkg::decoded_instr_t exp;
        if (ref_q.size() == 0) begin
            abort_run("The DUT presented an instruction that was never sent");
        end
        exp = ref_q.pop_front();
        check_value("o_instr.pc", o_instr.pc, exp.pc);
        check_value("o_instr.instr", o_instr.instr, exp.instr);
        check_value("o_instr.iclass", o_instr.iclass, exp.iclass);
        check_value("o_instr.target", o_instr.target, exp.target);
    endtask

    task automatic receive_one();
        int waited;
        waited = 0;
        while (!o_instr_valid) begin
            if (waited == TIMEOUT) begin
                abort_run("Timeout while waiting for o_instr_valid to rise");
            end
            step();
            waited++;
        end
        check_head();
        i_dec_accept = 1'b1;
        step();
        i_dec_accept = 1'b0;
    endtask

    task automatic single_word(input fetch_pkg::addr_t pc, input isa_pkg::instr_t w,
                               input logic err, input isa_pkg::instr_class_e cls,
                               input fetch_pkg::addr_t tgt);
        expect_entry(pc, w, cls, tgt);
        send_resp(pc, w, err);
        receive_one();
    endtask

    task automatic reset_state();
        check_value("o_instr_valid", o_instr_valid, 1'b0);
        check_value("o_resp_ready", o_resp_ready, 1'b1);
    endtask

    task automatic one_word_per_class();
        single_word(32'h100, 32'h0050_0093, 1'b0, isa_pkg::CLS_ALU, '0);
        single_word(32'h104, 32'h0000_a103, 1'b0, isa_pkg::CLS_LOAD, '0);
        single_word(32'h108, 32'h0020_a223, 1'b0, isa_pkg::CLS_STORE, '0);
        single_word(32'h10c, encode_branch(-8), 1'b0, isa_pkg::CLS_BRANCH, 32'h104);
        single_word(32'h110, encode_jal(32'h1abc), 1'b0, isa_pkg::CLS_JAL, 32'h1bcc);
        single_word(32'h114, 32'h0002_80e7, 1'b0, isa_pkg::CLS_JALR, '0);
        single_word(32'h118, 32'h0000_0073, 1'b0, isa_pkg::CLS_SYSTEM, '0);
        single_word(32'h11c, 32'h0000_007f, 1'b0, isa_pkg::CLS_ILLEGAL, '0);
        // c.li a0, 0 is a compressed word
        single_word(32'h120, 32'h0000_4501, 1'b0, isa_pkg::CLS_ILLEGAL, '0);
    endtask

    task automatic fault_tagging();
        single_word(32'h200, 32'h0050_0093, 1'b1, isa_pkg::CLS_FAULT, '0);
        single_word(32'h206, encode_jal(16), 1'b0, isa_pkg::CLS_FAULT, '0);
    endtask

    // Output register plus a full queue hold DEPTH+1 words once the capture stage drains
    task automatic fill_and_drain();
        int               sent;
        fetch_pkg::addr_t pc;
        isa_pkg::instr_t  w;
        sent         = 0;
        i_dec_accept = 1'b0;
        for (int c = 0; c < 4 * DEPTH; c++) begin
            if (o_resp_ready) begin
                pc           = 32'h400 + 4 * sent;
                w            = 32'h0000_0013 | (sent << 20);
                i_resp_valid = 1'b1;
                i_resp_addr  = pc;
                i_resp_data  = w;
                expect_model(pc, w, 1'b0);
                sent++;
            end else begin
                i_resp_valid = 1'b0;
            end
            step();
        end
        i_resp_valid = 1'b0;
        check_value("o_resp_ready", o_resp_ready, 1'b0);
        check_value("stored word count", sent, DEPTH + 1);
        repeat (sent) begin
            receive_one();
        end
        check_value("reference queue size", ref_q.size(), 0);
    endtask

    task automatic random_burst();
        int               sent;
        int               got;
        int               cycles;
        logic [31:0]      r;
        fetch_pkg::addr_t pc;
        isa_pkg::instr_t  w;
        sent   = 0;
        got    = 0;
        cycles = 0;
        while (got < BURST) begin
            if (cycles == 50 * BURST) begin
                abort_run("Timeout while draining the random burst");
            end
            r = $random(seed);
            if (o_instr_valid && r[0]) begin
                check_head();
                i_dec_accept = 1'b1;
                got++;
            end else begin
                i_dec_accept = 1'b0;
            end
            if ((sent < BURST) && o_resp_ready && r[1]) begin
                pc           = 32'h3000 + 4 * sent;
                w            = random_word();
                i_resp_valid = 1'b1;
                i_resp_addr  = pc;
                i_resp_data  = w;
                expect_model(pc, w, 1'b0);
                sent++;
            end else begin
                i_resp_valid = 1'b0;
            end
            step();
            cycles++;
        end
        i_dec_accept = 1'b0;
        i_resp_valid = 1'b0;
    endtask

    initial begin
        seed         = 32'h7083_df95;
        i_clk        = 1'b0;
        i_nrst       = 1'b0;
        i_resp_valid = 1'b0;
        i_resp_addr  = '0;
        i_resp_data  = '0;
        i_resp_err   = 1'b0;
        i_dec_accept = 1'b0;
        repeat (4) begin
            @(posedge i_clk);
        end
        #1;
        i_nrst = 1'b1;

        reset_state();
        one_word_per_class();
        fault_tagging();
        fill_and_drain();
        random_burst();

        if (ref_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run("Expected instructions never came out of the DUT");
        end
    end

endmodule

`default_nettype wire

/* test/fetch_buffer_assertions.sv */
// Concurrent protocol checks on the fetch buffer top level, attached by bind
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer_assertions (
    input wire logic                      i_clk,
    input wire logic                      i_nrst,
    input wire logic                      i_resp_valid,
    input wire logic                      i_resp_ready,
    input wire logic                      i_dec_accept,
    input wire logic                      i_instr_valid,
    input wire fetch_pkg::decoded_instr_t i_instr
);

    // Memory may only respond while the queue has room
    resp_only_when_ready: assert property (
        @(posedge i_clk) disable iff (!i_nrst) i_resp_valid |-> i_resp_ready
    ) else $error("memory response while o_resp_ready was low");

    // A held instruction must not change until the decoder takes it
    hold_stable: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (i_instr_valid && !i_dec_accept) |=> (i_instr_valid && $stable(i_instr))
    ) else $error("o_instr changed while held without accept");

    accept_needs_valid: assert property (
        @(posedge i_clk) disable iff (!i_nrst) i_dec_accept |-> i_instr_valid
    ) else $error("i_dec_accept high while o_instr_valid was low");

    valid_low_in_reset: assert property (
        @(posedge i_clk) !i_nrst |-> !i_instr_valid
    ) else $error("o_instr_valid high during reset");

endmodule

bind fetch_buffer_top fetch_buffer_assertions assertions_i (
    .i_clk         (i_clk),
    .i_nrst        (i_nrst),
    .i_resp_valid  (i_resp_valid),
    .i_resp_ready  (o_resp_ready),
    .i_dec_accept  (i_dec_accept),
    .i_instr_valid (o_instr_valid),
    .i_instr       (o_instr)
);

`default_nettype wire

/* hw/fetch_buffer_top.sv */
// Instruction fetch buffer joining the capture stage, the entry queue and the predecoder
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer_top #(
    parameter int ABITS = 3
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_nrst,
    input  wire logic                      i_resp_valid,
    input  wire fetch_pkg::addr_t          i_resp_addr,
    input  wire isa_pkg::instr_t           i_resp_data,
    input  wire logic                      i_resp_err,
    output logic                           o_resp_ready,
    input  wire logic                      i_dec_accept,
    output logic                           o_instr_valid,
    output fetch_pkg::decoded_instr_t      o_instr
);

    logic                    cap_we;
    fetch_pkg::fetch_entry_t cap_entry;
    fetch_pkg::fetch_entry_t q_rdata;
    logic                    q_full;
    logic                    q_nempty;
    logic                    q_re;

    fetch_capture capture_i (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_resp_valid (i_resp_valid),
        .i_resp_addr  (i_resp_addr),
        .i_resp_data  (i_resp_data),
        .i_resp_err   (i_resp_err),
        .o_we         (cap_we),
        .o_entry      (cap_entry)
    );

    fetch_queue #(
        .ABITS (ABITS)
    ) queue_i (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_re     (q_re),
        .i_we     (cap_we),
        .i_wdata  (cap_entry),
        .o_rdata  (q_rdata),
        .o_full   (q_full),
        .o_nempty (q_nempty)
    );

    instr_predecode predecode_i (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_rdata       (q_rdata),
        .i_nempty      (q_nempty),
        .o_re          (q_re),
        .i_dec_accept  (i_dec_accept),
        .o_instr_valid (o_instr_valid),
        .o_instr       (o_instr)
    );

    // Memory may only respond while the queue has room for two more entries
    assign o_resp_ready = ~q_full;

endmodule

`default_nettype wire

/* hw/instr_predecode.sv */
// Output stage that pops fetch entries, classifies them and holds the result for the decoder
`timescale 1ns/1ns
`default_nettype none

module instr_predecode (
    input  wire logic                    i_clk,
    input  wire logic                    i_nrst,
    input  wire fetch_pkg::fetch_entry_t i_rdata,
    input  wire logic                    i_nempty,
    output logic                         o_re,
    input  wire logic                    i_dec_accept,
    output logic                         o_instr_valid,
    output fetch_pkg::decoded_instr_t    o_instr
);

    fetch_pkg::out_state_e     state_q;
    fetch_pkg::out_state_e     state_d;
    fetch_pkg::decoded_instr_t out_q;
    fetch_pkg::decoded_instr_t out_d;
    logic                      pop;

    // Faults win over everything, then compressed words, then the major opcode
    function automatic isa_pkg::instr_class_e classify(input fetch_pkg::fetch_entry_t e);
        isa_pkg::instr_class_e cls;
        cls = isa_pkg::CLS_ILLEGAL;
        if (e.bus_err || e.misaligned) begin
            cls = isa_pkg::CLS_FAULT;
        end else if (e.instr[1:0] != 2'b11) begin
            cls = isa_pkg::CLS_ILLEGAL;
        end else begin
            case (e.instr[6:0])
                isa_pkg::OPC_OP,
                isa_pkg::OPC_OP_IMM,
                isa_pkg::OPC_LUI,
                isa_pkg::OPC_AUIPC:  cls = isa_pkg::CLS_ALU;
                isa_pkg::OPC_LOAD:   cls = isa_pkg::CLS_LOAD;
                isa_pkg::OPC_STORE:  cls = isa_pkg::CLS_STORE;
                isa_pkg::OPC_BRANCH: cls = isa_pkg::CLS_BRANCH;
                isa_pkg::OPC_JAL:    cls = isa_pkg::CLS_JAL;
                isa_pkg::OPC_JALR:   cls = isa_pkg::CLS_JALR;
                isa_pkg::OPC_SYSTEM: cls = isa_pkg::CLS_SYSTEM;
                default:             cls = isa_pkg::CLS_ILLEGAL;
            endcase
        end
        return cls;
    endfunction

    // Only direct control transfers get a target because JALR depends on a register
    function automatic fetch_pkg::addr_t calc_target(
        input fetch_pkg::addr_t      pc,
        input isa_pkg::instr_t       w,
        input isa_pkg::instr_class_e cls
    );
        fetch_pkg::addr_t b_imm;
        fetch_pkg::addr_t j_imm;
        fetch_pkg::addr_t tgt;
        b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (cls)
            isa_pkg::CLS_BRANCH: tgt = pc + b_imm;
            isa_pkg::CLS_JAL:    tgt = pc + j_imm;
            default:             tgt = '0;
        endcase
        return tgt;
    endfunction

    always_comb begin
        out_d.pc     = i_rdata.pc;
        out_d.instr  = i_rdata.instr;
        out_d.iclass = classify(i_rdata);
        out_d.target = calc_target(i_rdata.pc, i_rdata.instr, out_d.iclass);
    end

    // In HOLD an accept with more data waiting reloads on the same edge
    always_comb begin
        pop     = 1'b0;
        state_d = state_q;
        case (state_q)
            fetch_pkg::OUT_EMPTY: begin
                if (i_nempty) begin
                    pop     = 1'b1;
                    state_d = fetch_pkg::OUT_HOLD;
                end
            end
            fetch_pkg::OUT_HOLD: begin
                if (i_dec_accept) begin
                    pop     = i_nempty;
                    state_d = i_nempty ? fetch_pkg::OUT_HOLD : fetch_pkg::OUT_EMPTY;
                end
            end
            default: state_d = fetch_pkg::OUT_EMPTY;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= fetch_pkg::OUT_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (pop) begin
            out_q <= out_d;
        end
    end

    assign o_re          = pop;
    assign o_instr_valid = (state_q == fetch_pkg::OUT_HOLD);
    assign o_instr       = out_q;

endmodule

`default_nettype wire

/* hw/fetch_queue.sv */
// Fall-through shift-register queue of fetch entries with early full indication
`timescale 1ns/1ns
`default_nettype none

module fetch_queue #(
    parameter int ABITS = 3
) (
    input  wire logic                    i_clk,
    input  wire logic                    i_nrst,
    input  wire logic                    i_re,
    input  wire logic                    i_we,
    input  wire fetch_pkg::fetch_entry_t i_wdata,
    output fetch_pkg::fetch_entry_t      o_rdata,
    output logic                         o_full,
    output logic                         o_nempty
);

    localparam int DEPTH = 2 ** ABITS;

    fetch_pkg::fetch_entry_t mem_q [DEPTH];
    fetch_pkg::fetch_entry_t mem_d [DEPTH];
    logic [ABITS:0]          cnt_q;
    logic [ABITS:0]          cnt_d;
    logic [ABITS:0]          cnt_m1;
    logic                    empty;
    logic                    full;

    assign empty  = (cnt_q == '0);
    assign full   = (cnt_q == DEPTH[ABITS:0]);
    assign cnt_m1 = cnt_q - 1'b1;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            mem_d[i] = mem_q[i];
        end
        cnt_d = cnt_q;

        if (i_re && i_we) begin
            // Shift down and refill the slot freed at the top
            for (int i = 1; i < DEPTH; i++) begin
                mem_d[i - 1] = mem_q[i];
            end
            // When empty the write data goes straight out and nothing is kept
            if (!empty) begin
                mem_d[cnt_m1[ABITS-1:0]] = i_wdata;
            end
        end else if (i_we) begin
            // A push into a completely full queue is dropped
            if (!full) begin
                mem_d[cnt_q[ABITS-1:0]] = i_wdata;
                cnt_d = cnt_q + 1'b1;
            end
        end else if (i_re) begin
            for (int i = 1; i < DEPTH; i++) begin
                mem_d[i - 1] = mem_q[i];
            end
            if (!empty) begin
                cnt_d = cnt_m1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            mem_q[i] <= mem_d[i];
        end
    end

    // Head of queue, or the incoming word when nothing is stored yet
    assign o_rdata  = empty ? i_wdata : mem_q[0];
    assign o_nempty = i_we || !empty;

    // Raised one slot early so the word sitting in the capture stage still fits
    assign o_full   = (cnt_q >= (DEPTH - 1));

endmodule

`default_nettype wire

/* hw/fetch_capture.sv */
// Input stage that registers memory responses into tagged fetch entries
`timescale 1ns/1ns
`default_nettype none

module fetch_capture (
    input  wire logic                    i_clk,
    input  wire logic                    i_nrst,
    input  wire logic                    i_resp_valid,
    input  wire fetch_pkg::addr_t        i_resp_addr,
    input  wire isa_pkg::instr_t         i_resp_data,
    input  wire logic                    i_resp_err,
    output logic                         o_we,
    output fetch_pkg::fetch_entry_t      o_entry
);

    logic                    valid_q;
    fetch_pkg::fetch_entry_t entry_q;
    fetch_pkg::fetch_entry_t entry_d;

    // Tag the response with its fault bits before it is stored
    always_comb begin
        entry_d.pc         = i_resp_addr;
        entry_d.instr      = i_resp_data;
        entry_d.bus_err    = i_resp_err;
        entry_d.misaligned = |i_resp_addr[1:0];
    end

    // The valid bit lasts exactly one cycle per response
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_resp_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_resp_valid) begin
            entry_q <= entry_d;
        end
    end

    // The queue write happens in the cycle after the response was taken
    assign o_we    = valid_q;
    assign o_entry = entry_q;

endmodule

`default_nettype wire

/* hw/fetch_pkg.sv */
// Fetch path types: addresses, queue entries, predecoded results and output FSM states
`default_nettype none

package fetch_pkg;

    // Byte address of an instruction
    typedef logic [31:0] addr_t;

    // One memory response as stored in the fetch queue, 66 bits
    typedef struct packed {
        addr_t           pc;
        isa_pkg::instr_t instr;
        logic            bus_err;
        logic            misaligned;
    } fetch_entry_t;

    // Predecoded instruction presented to the decoder, 100 bits
    typedef struct packed {
        addr_t                 pc;
        isa_pkg::instr_t       instr;
        isa_pkg::instr_class_e iclass;
        addr_t                 target;
    } decoded_instr_t;

    // Output register is either empty or holding a result for the decoder
    typedef enum logic {
        OUT_EMPTY = 1'b0,
        OUT_HOLD  = 1'b1
    } out_state_e;

endpackage

`default_nettype wire

/* hw/isa_pkg.sv */
// RV32I instruction word type, major opcode constants and instruction classes
`default_nettype none

package isa_pkg;

    // One uncompressed RV32I instruction
    typedef logic [31:0] instr_t;

    // Major opcode field, bits 6:0 of the instruction
    typedef logic [6:0] opcode_t;

    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // Coarse class handed to the decoder along with the word
    typedef enum logic [3:0] {
        CLS_ALU     = 4'd0,
        CLS_LOAD    = 4'd1,
        CLS_STORE   = 4'd2,
        CLS_BRANCH  = 4'd3,
        CLS_JAL     = 4'd4,
        CLS_JALR    = 4'd5,
        CLS_SYSTEM  = 4'd6,
        CLS_ILLEGAL = 4'd7,
        CLS_FAULT   = 4'd8
    } instr_class_e;

endpackage

`default_nettype wire
